// File: Bender.yml
package:
  name: smc

export_include_dirs:
  - src

sources:
  - src/smc_pkg.sv
  - src/smc_ahb_if.sv
  - src/smc_timing.sv
  - src/smc_emi.sv
  - src/smc_top.sv
  - target: test
    files:
      - bench/tb_smc.sv

// File: bench/smc_tests.txt
# op haddr hsize data expected, all hex, op W is a write and R a read
# Read expected is the masked read data, for hsize 3 it is the hresp code
W 00000000 2 12345678 00000000
R 00000000 2 00000000 12345678
W 00000014 2 a5a5a5a5 00000000
W 00000015 0 00003c00 00000000
W 00000016 1 beef0000 00000000
R 00000014 2 00000000 beef3ca5
R 00000015 0 00000000 00003c00
R 00000016 1 00000000 beef0000
W 00000028 2 cafef00d 00000000
W 0000002b 0 99000000 00000000
W 00000028 1 00001234 00000000
R 00000028 2 00000000 99fe1234
R 0000002a 0 00000000 00fe0000
W 0000003c 2 0badf00d 00000000
R 0000003c 2 00000000 0badf00d
W 00000004 3 11112222 00000001
R 00000008 3 00000000 00000001
R 00000000 0 00000000 00000078
R 00000003 0 00000000 12000000
R 00000002 1 00000000 12340000

// File: bench/tb_smc.sv
//----------------------------------------------------------------------
// Testbench for the static memory controller
// Clock and reset, AHB master driver, 16-word SRAM model, reference
// memory with the lane rule, strobe order, latency and response checks
//----------------------------------------------------------------------

`timescale 1ns/1ps

`include "smc_defs.svh"

module tb_smc;

  localparam time CLK_PERIOD  = 100ns;
  localparam int  TIMEOUT_CYC = 50;   // Per wait for smc_hready
  localparam int  MEM_WORDS   = 16;
  localparam int  STB_CYCLES  = `SMC_WS_CYCLES + 1;
  localparam int  LATENCY     = `SMC_CSLE_CYCLES + `SMC_WS_CYCLES + `SMC_CSTE_CYCLES + 3;

  logic                   hclk;
  logic                   rst_n;
  logic [`SMC_ADDR_W-1:0] haddr;
  smc_pkg::htrans_e       htrans;
  logic                   hsel;
  logic                   hwrite;
  logic [2:0]             hsize;
  logic [`SMC_DATA_W-1:0] hwdata;
  logic                   hready;
  logic [`SMC_DATA_W-1:0] smc_hrdata;
  logic                   smc_hready;
  smc_pkg::hresp_e        smc_hresp;
  logic [`SMC_ADDR_W-1:0] smc_addr;
  logic [`SMC_DATA_W-1:0] smc_data;
  logic [`SMC_DATA_W-1:0] data_smc;
  logic [3:0]             smc_n_be;
  logic [3:0]             smc_n_we;
  logic                   smc_n_cs;
  logic                   smc_n_rd;
  logic                   smc_n_wr;
  logic                   smc_n_ext_oe;
  logic                   smc_busy;

  logic [31:0] sram   [MEM_WORDS];  // External memory model
  logic [31:0] shadow [MEM_WORDS];  // Reference contents
  integer      seed;
  int          checks;
  int          errors;
  int          timeouts;

  assign hready = smc_hready;  // Single slave on the bus

  smc_top i_dut (
    .hclk (hclk), .rst_n (rst_n), .haddr (haddr), .htrans (htrans), .hsel (hsel),
    .hwrite (hwrite), .hsize (hsize), .hwdata (hwdata), .hready (hready),
    .smc_hrdata (smc_hrdata), .smc_hready (smc_hready), .smc_hresp (smc_hresp),
    .smc_addr (smc_addr), .smc_data (smc_data), .data_smc (data_smc),
    .smc_n_be (smc_n_be), .smc_n_we (smc_n_we), .smc_n_cs (smc_n_cs),
    .smc_n_rd (smc_n_rd), .smc_n_wr (smc_n_wr), .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy (smc_busy)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  // SRAM model on the falling edge
  always @(negedge hclk) begin
    if (!smc_n_cs) begin
      for (int l = 0; l < 4; l++) begin
        if (!smc_n_we[l]) sram[smc_addr[5:2]][8*l +: 8] <= smc_data[8*l +: 8];
      end
    end
    data_smc <= !smc_n_rd ? sram[smc_addr[5:2]] : 32'h0;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  // Little endian lanes of one transfer
  function automatic logic [31:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
    case (size)
      3'd0:    lane_mask = 32'hff << (8 * addr[1:0]);
      3'd1:    lane_mask = addr[1] ? 32'hffff_0000 : 32'h0000_ffff;
      default: lane_mask = 32'hffff_ffff;
    endcase
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // One AHB transfer between two falling edges
  task automatic run_transfer(input logic [7:0] op, input logic [31:0] addr,
                              input logic [2:0] size, input logic [31:0] data,
                              input logic [31:0] expected);
    logic [31:0] mask;
    logic [31:0] wr_word;
    logic [3:0]  n_be_exp;
    logic        is_write;
    logic        bad_size;
    logic        done;
    int          cyc;
    int          first_cs;
    int          last_cs;
    int          first_stb;
    int          last_stb;
    int          stb_len;
    is_write = (op == "W");
    bad_size = (size > 3'd2);
    mask     = lane_mask(addr, size);
    n_be_exp = ~{mask[24], mask[16], mask[8], mask[0]};
    wr_word  = (data & mask) | ($random(seed) & ~mask);  // Random idle lanes
    first_cs = -1;
    last_cs  = -1;
    first_stb = -1;
    last_stb = -1;
    stb_len  = 0;
    haddr  = addr;     // Address phase
    hsize  = size;
    hwrite = is_write;
    hsel   = 1'b1;
    htrans = smc_pkg::NONSEQ;
    @(posedge hclk);
    @(negedge hclk);
    hsel   = 1'b0;
    htrans = smc_pkg::IDLE;
    hwdata = wr_word;  // Data phase
    cyc    = 1;
    done   = 1'b0;
    while (!done && cyc <= TIMEOUT_CYC) begin
      if (!smc_n_cs) begin
        if (first_cs < 0) first_cs = cyc;
        last_cs = cyc;
        expect_equal("smc_busy", smc_busy, 1'b1);
        expect_equal("smc_n_be", smc_n_be, n_be_exp);
        expect_equal("smc_addr", smc_addr, {addr[31:2], 2'b00});
      end
      if (!(smc_n_rd & smc_n_wr)) begin
        if (first_stb < 0) first_stb = cyc;
        last_stb = cyc;
        stb_len++;
        expect_equal("smc_n_rd", smc_n_rd, is_write);
        expect_equal("smc_n_wr", smc_n_wr, !is_write);
        expect_equal("smc_n_we", smc_n_we, is_write ? n_be_exp : 4'hf);
        expect_equal("smc_n_ext_oe", smc_n_ext_oe, !is_write);
      end
      if (bad_size) expect_equal("smc_hresp", 32'(smc_hresp), 32'(smc_pkg::ERROR));
      if (smc_hready) begin
        done = 1'b1;
      end else begin
        @(negedge hclk);
        cyc++;
      end
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: smc_hready stayed low for %0d cycles, %c at %h", TIMEOUT_CYC, op, addr);
      return;
    end
    checks++;
    if (bad_size) begin
      expect_equal("latency", cyc, 2);
      expect_equal("smc_hresp", 32'(smc_hresp), expected);
      // Long enough for a whole external cycle to show
      repeat (LATENCY) begin
        @(negedge hclk);
        if (!smc_n_cs) first_cs = cyc;
      end
      if (first_cs >= 0) begin
        errors++;
        $display("Chip select fell on an unsupported size at %h", addr);
      end
    end else begin
      expect_equal("latency", cyc, LATENCY);
      expect_equal("smc_hresp", 32'(smc_hresp), 32'(smc_pkg::OKAY));
      expect_equal("strobe low cycles", stb_len, STB_CYCLES);
      if (first_cs < 0 || first_stb <= first_cs || last_stb >= last_cs) begin
        errors++;
        $display("Chip select did not frame the strobe, %c at %h", op, addr);
      end
      if (is_write) begin
        shadow[addr[5:2]] = (shadow[addr[5:2]] & ~mask) | (wr_word & mask);
      end else begin
        expect_equal("smc_hrdata masked", smc_hrdata & mask, expected);
        expect_equal("smc_hrdata", smc_hrdata, shadow[addr[5:2]]);  // Idle lanes kept
      end
    end
    @(posedge hclk);   // Data phase completes
    @(negedge hclk);
    expect_equal("smc_n_cs after access", smc_n_cs, 1'b1);
    expect_equal("smc_n_be after access", smc_n_be, 4'hf);
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    integer      fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] size_w;
    logic [31:0] data;
    logic [31:0] expv;
    checks = 0;
    errors = 0;
    timeouts = 0;
    seed   = 32'hb35;
    rst_n  = 1'b0;
    haddr  = '0;
    htrans = smc_pkg::IDLE;
    hsel   = 1'b0;
    hwrite = 1'b0;
    hsize  = 3'd0;
    hwdata = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      sram[i]   = $random(seed);
      shadow[i] = sram[i];
    end
    repeat (16) @(posedge hclk);
    @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);
    // Everything idle after reset
    expect_equal("smc_n_cs", smc_n_cs, 1'b1);
    expect_equal("smc_n_rd", smc_n_rd, 1'b1);
    expect_equal("smc_n_wr", smc_n_wr, 1'b1);
    expect_equal("smc_n_ext_oe", smc_n_ext_oe, 1'b1);
    expect_equal("smc_n_we", smc_n_we, 4'hf);
    expect_equal("smc_n_be", smc_n_be, 4'hf);
    expect_equal("smc_busy", smc_busy, 1'b0);
    expect_equal("smc_hready", smc_hready, 1'b1);
    expect_equal("smc_hresp", 32'(smc_hresp), 32'(smc_pkg::OKAY));
    fd = $fopen("bench/smc_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open bench/smc_tests.txt");
    end else begin
      while (!$feof(fd) && timeouts == 0) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          // Comment and blank lines do not give five fields
          if ($sscanf(line, "%c %h %h %h %h", op, addr, size_w, data, expv) == 5) begin
            run_transfer(op, addr, size_w[2:0], data, expv);
          end
        end
      end
      $fclose(fd);
    end
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: src/smc_ahb_if.sv
//----------------------------------------------------------------------
// AHB-Lite slave front end
// Address phase qualify, size check, request and write data capture
// Ready and response sequencing, two-cycle ERROR for bad sizes
//----------------------------------------------------------------------

`timescale 1ns/1ps

`include "smc_defs.svh"

module smc_ahb_if (
  input  logic                   hclk,
  input  logic                   rst_n,
  // AHB slave inputs
  input  logic [`SMC_ADDR_W-1:0] haddr,
  input  smc_pkg::htrans_e       htrans,
  input  logic                   hsel,
  input  logic                   hwrite,
  input  logic                   hready,       // Muxed bus ready
  input  logic [2:0]             hsize,
  input  logic [`SMC_DATA_W-1:0] hwdata,
  // From timing and EMI
  input  smc_pkg::smc_phase_e    phase,
  input  logic [`SMC_DATA_W-1:0] rd_data,
  // To timing and EMI
  output smc_pkg::smc_req_t      req,
  output logic                   req_valid,    // One cycle, first data phase cycle
  output logic [`SMC_DATA_W-1:0] wdata,
  // AHB slave outputs
  output logic [`SMC_DATA_W-1:0] smc_hrdata,
  output logic                   smc_hready,
  output smc_pkg::hresp_e        smc_hresp
);

  logic accept;      // Valid address phase this cycle
  logic size_ok;     // Byte, half or word
  logic busy_q;      // Data phase of a good transfer pending
  logic err_first;   // First ERROR cycle, hready low
  logic err_second;  // Second ERROR cycle, hready high

  //--------------------------------------------------------------------
  // Address phase
  //--------------------------------------------------------------------
  assign accept = hsel & hready &
                  ((htrans == smc_pkg::NONSEQ) | (htrans == smc_pkg::SEQ));

  assign size_ok = (hsize <= {1'b0, `SMC_SIZE_WORD});  // Nothing wider than a word

  // Control state
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid  <= 1'b0;
      busy_q     <= 1'b0;
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      req_valid  <= accept & size_ok;    // Kicks off the external cycle
      err_first  <= accept & ~size_ok;   // Bad size, no external cycle
      err_second <= err_first;
      if (accept && size_ok) begin
        busy_q <= 1'b1;                  // New transfer wins over the clear
      end else if (phase == smc_pkg::PH_DONE) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request payload
  always_ff @(posedge hclk) begin
    if (accept && size_ok) begin
      req.addr  <= haddr;
      req.size  <= hsize[1:0];
      req.write <= hwrite;
    end
  end

  // hwdata is valid in the first data phase cycle
  always_ff @(posedge hclk) begin
    if (req_valid && req.write) begin
      wdata <= hwdata;
    end
  end

  //--------------------------------------------------------------------
  // Data phase response
  //--------------------------------------------------------------------
  // Wait states until the cycle reaches DONE
  assign smc_hready = ~err_first & (~busy_q | (phase == smc_pkg::PH_DONE));

  assign smc_hresp  = (err_first | err_second) ? smc_pkg::ERROR : smc_pkg::OKAY;

  assign smc_hrdata = rd_data;  // Held by the EMI read latch

endmodule

// File: src/smc_defs.svh
//----------------------------------------------------------------------
// Static memory controller build constants
// Bus widths, external cycle timing counts, transfer size codes
//----------------------------------------------------------------------

`ifndef SMC_DEFS_SVH
`define SMC_DEFS_SVH

// Bus widths
`define SMC_ADDR_W 32   // AHB and EMI address
`define SMC_DATA_W 32   // AHB and EMI data, always a full word
`define SMC_CNT_W  8    // Phase down-counter

//----------------------------------------------------------------------
// External cycle timing, in hclk cycles
//----------------------------------------------------------------------
`define SMC_CSLE_CYCLES 1   // Chip select low to strobe low
`define SMC_WS_CYCLES   2   // Strobe length minus one
`define SMC_CSTE_CYCLES 1   // Strobe high to chip select high

// Transfer size codes, same as hsize[1:0]
`define SMC_SIZE_BYTE 2'd0
`define SMC_SIZE_HALF 2'd1
`define SMC_SIZE_WORD 2'd2

`endif

// File: src/smc_emi.sv
//----------------------------------------------------------------------
// External memory interface
// Word address, byte enables, registered strobes and chip select
// Write data drive and read data latch
//----------------------------------------------------------------------

`timescale 1ns/1ps

`include "smc_defs.svh"

module smc_emi (
  input  logic                   hclk,
  input  logic                   rst_n,
  input  smc_pkg::smc_req_t      req,
  input  logic                   req_valid,
  input  logic [`SMC_DATA_W-1:0] wdata,
  input  smc_pkg::smc_phase_e    phase,
  input  logic                   latch_data,
  input  logic [`SMC_DATA_W-1:0] data_smc,     // Read data from memory
  output logic [`SMC_DATA_W-1:0] rd_data,
  output logic [`SMC_ADDR_W-1:0] smc_addr,
  output logic [`SMC_DATA_W-1:0] smc_data,
  output logic [3:0]             smc_n_be,
  output logic [3:0]             smc_n_we,
  output logic                   smc_n_cs,
  output logic                   smc_n_rd,
  output logic                   smc_n_wr,
  output logic                   smc_n_ext_oe
);

  logic [3:0] be;         // Decoded lanes, active high
  logic       wr_q;       // Current access is a write
  logic       in_strobe;
  logic       cs_active;

  //--------------------------------------------------------------------
  // Lane decode, little endian
  //--------------------------------------------------------------------
  always_comb begin
    case (req.size)
      `SMC_SIZE_BYTE: be = 4'b0001 << req.addr[1:0];
      `SMC_SIZE_HALF: be = req.addr[1] ? 4'b1100 : 4'b0011;
      default:        be = 4'b1111;    // Word
    endcase
  end

  // Address, word aligned
  always_ff @(posedge hclk) begin
    if (req_valid) begin
      smc_addr <= {req.addr[`SMC_ADDR_W-1:2], 2'b00};
    end
  end

  // Byte enables and direction, held for the whole access
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      smc_n_be <= 4'hf;
      wr_q     <= 1'b0;
    end else if (req_valid) begin
      smc_n_be <= ~be;
      wr_q     <= req.write;
    end else if (phase == smc_pkg::PH_DONE) begin
      smc_n_be <= 4'hf;      // Back to inactive between accesses
    end
  end

  //--------------------------------------------------------------------
  // Strobes, one cycle behind the phase
  //--------------------------------------------------------------------
  assign in_strobe = (phase == smc_pkg::PH_STROBE);
  assign cs_active = (phase == smc_pkg::PH_LEAD) | in_strobe |
                     (phase == smc_pkg::PH_TRAIL);

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= 4'hf;
      smc_n_ext_oe <= 1'b1;
    end else begin
      smc_n_cs     <= ~cs_active;
      smc_n_rd     <= ~(in_strobe & ~wr_q);
      smc_n_wr     <= ~(in_strobe & wr_q);
      smc_n_we     <= (in_strobe & wr_q) ? smc_n_be : 4'hf;  // Enabled lanes only
      smc_n_ext_oe <= ~(in_strobe & wr_q);                   // Drive bus on writes
    end
  end

  // Data paths
  assign smc_data = wdata;

  always_ff @(posedge hclk) begin
    if (latch_data) begin
      rd_data <= data_smc;   // Sampled at strobe end
    end
  end

endmodule

// File: src/smc_pkg.sv
//----------------------------------------------------------------------
// Shared types of the static memory controller
// Request struct, cycle phase, AHB transfer and response codes
//----------------------------------------------------------------------

`include "smc_defs.svh"

package smc_pkg;

  // Registered AHB request, handed from bus side to EMI
  typedef struct packed {
    logic [`SMC_ADDR_W-1:0] addr;  // Byte address as seen on haddr
    logic [1:0]             size;  // Byte, half or word
    logic                   write; // High for a write
  } smc_req_t;

  // External cycle phases
  typedef enum logic [2:0] {
    PH_IDLE   = 3'd0,  // No access
    PH_LEAD   = 3'd1,  // CS low, strobe still high
    PH_STROBE = 3'd2,  // Read or write strobe low
    PH_TRAIL  = 3'd3,  // Strobe back high, CS held
    PH_DONE   = 3'd4   // AHB data phase completes
  } smc_phase_e;

  // AHB-Lite transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // AHB-Lite response, only two codes used here
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

endpackage

// File: src/smc_timing.sv
//----------------------------------------------------------------------
// External cycle timing FSM
// Lead, strobe and trail phases from one shared down-counter
// Read latch pulse and busy flag
//----------------------------------------------------------------------

`timescale 1ns/1ps

`include "smc_defs.svh"

module smc_timing (
  input  logic                hclk,
  input  logic                rst_n,
  input  logic                req_valid,   // Start of a new access
  output smc_pkg::smc_phase_e phase,
  output logic                latch_data,  // Last strobe cycle
  output logic                smc_busy
);

  // Counter reload values, one per timed phase
  localparam logic [`SMC_CNT_W-1:0] CSLE_LOAD = `SMC_CNT_W'(`SMC_CSLE_CYCLES - 1);
  localparam logic [`SMC_CNT_W-1:0] WS_LOAD   = `SMC_CNT_W'(`SMC_WS_CYCLES);
  localparam logic [`SMC_CNT_W-1:0] CSTE_LOAD = `SMC_CNT_W'(`SMC_CSTE_CYCLES - 1);

  smc_pkg::smc_phase_e    phase_q;
  smc_pkg::smc_phase_e    phase_nxt;
  logic [`SMC_CNT_W-1:0]  cnt_q;      // Cycles left in this phase, minus one
  logic [`SMC_CNT_W-1:0]  cnt_nxt;
  logic                   cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  //--------------------------------------------------------------------
  // Next phase and counter
  //--------------------------------------------------------------------
  always_comb begin
    phase_nxt = phase_q;
    cnt_nxt   = cnt_zero ? cnt_q : cnt_q - 1'b1;  // Count down, park at zero
    case (phase_q)
      smc_pkg::PH_IDLE: begin
        if (req_valid) begin
          if (`SMC_CSLE_CYCLES != 0) begin
            phase_nxt = smc_pkg::PH_LEAD;
            cnt_nxt   = CSLE_LOAD;
          end else begin
            phase_nxt = smc_pkg::PH_STROBE;   // No lead time
            cnt_nxt   = WS_LOAD;
          end
        end
      end
      smc_pkg::PH_LEAD: begin
        if (cnt_zero) begin
          phase_nxt = smc_pkg::PH_STROBE;
          cnt_nxt   = WS_LOAD;
        end
      end
      smc_pkg::PH_STROBE: begin
        if (cnt_zero) begin
          if (`SMC_CSTE_CYCLES != 0) begin
            phase_nxt = smc_pkg::PH_TRAIL;
            cnt_nxt   = CSTE_LOAD;
          end else begin
            phase_nxt = smc_pkg::PH_DONE;     // CS released with strobe
          end
        end
      end
      smc_pkg::PH_TRAIL: begin
        if (cnt_zero) begin
          phase_nxt = smc_pkg::PH_DONE;
        end
      end
      smc_pkg::PH_DONE:  phase_nxt = smc_pkg::PH_IDLE;  // Single cycle
      default:           phase_nxt = smc_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= smc_pkg::PH_IDLE;
      cnt_q   <= '0;
    end else begin
      phase_q <= phase_nxt;
      cnt_q   <= cnt_nxt;
    end
  end

  //--------------------------------------------------------------------
  // Outputs
  //--------------------------------------------------------------------
  assign phase      = phase_q;
  assign latch_data = (phase_q == smc_pkg::PH_STROBE) & cnt_zero;  // Data settled
  assign smc_busy   = (phase_q != smc_pkg::PH_IDLE);

endmodule

// File: src/smc_top.sv
//----------------------------------------------------------------------
// Static memory controller top level
// AHB-Lite front end, cycle timing FSM and external memory interface
//----------------------------------------------------------------------

`timescale 1ns/1ps

`include "smc_defs.svh"

module smc_top (
  input  logic                   hclk,
  input  logic                   rst_n,
  // AHB-Lite slave
  input  logic [`SMC_ADDR_W-1:0] haddr,
  input  smc_pkg::htrans_e       htrans,
  input  logic                   hsel,
  input  logic                   hwrite,
  input  logic [2:0]             hsize,
  input  logic [`SMC_DATA_W-1:0] hwdata,
  input  logic                   hready,
  output logic [`SMC_DATA_W-1:0] smc_hrdata,
  output logic                   smc_hready,
  output smc_pkg::hresp_e        smc_hresp,
  // External memory
  output logic [`SMC_ADDR_W-1:0] smc_addr,
  output logic [`SMC_DATA_W-1:0] smc_data,
  input  logic [`SMC_DATA_W-1:0] data_smc,
  output logic [3:0]             smc_n_be,
  output logic [3:0]             smc_n_we,
  output logic                   smc_n_cs,
  output logic                   smc_n_rd,
  output logic                   smc_n_wr,
  output logic                   smc_n_ext_oe,
  output logic                   smc_busy
);

  smc_pkg::smc_req_t      req;
  logic                   req_valid;
  logic [`SMC_DATA_W-1:0] wdata;
  logic [`SMC_DATA_W-1:0] rd_data;
  smc_pkg::smc_phase_e    phase;
  logic                   latch_data;

  smc_ahb_if i_ahb_if (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .haddr      (haddr),
    .htrans     (htrans),
    .hsel       (hsel),
    .hwrite     (hwrite),
    .hready     (hready),
    .hsize      (hsize),
    .hwdata     (hwdata),
    .phase      (phase),
    .rd_data    (rd_data),
    .req        (req),
    .req_valid  (req_valid),
    .wdata      (wdata),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp)
  );

  smc_timing i_timing (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .phase      (phase),
    .latch_data (latch_data),
    .smc_busy   (smc_busy)
  );

  smc_emi i_emi (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .req          (req),
    .req_valid    (req_valid),
    .wdata        (wdata),
    .phase        (phase),
    .latch_data   (latch_data),
    .data_smc     (data_smc),
    .rd_data      (rd_data),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_we     (smc_n_we),
    .smc_n_cs     (smc_n_cs),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_ext_oe (smc_n_ext_oe)
  );

endmodule

// File: tb.f
+incdir+src
src/smc_pkg.sv
src/smc_ahb_if.sv
src/smc_timing.sv
src/smc_emi.sv
src/smc_top.sv
bench/tb_smc.sv
